// ==== hdl/trng_pkg.sv ====
package trng_pkg;

    // default sizing, overridden from the top level
    parameter int DEF_WINDOW_LEN = 1024;
    parameter int DEF_C_INTER = 8;
    parameter int DEF_C_PERM = 16;
    parameter int DEF_WORD_W = 32;

    // width of one trim code
    parameter int TRIM_W = 6;

    // ones count holds a full window, so one bit wider than the sample index
    parameter int CNT_W = $clog2(DEF_WINDOW_LEN) + 1;

    // trim image, same bit order as the debug register
    typedef struct packed {
        logic [TRIM_W-1:0] n_trim;
        logic [TRIM_W-1:0] p_trim;
    } trim_t;

    // run detector results
    typedef struct packed {
        logic inter_fail;
        logic rep_fail;
        logic run_value;
        logic armed;
    } run_flags_t;

    // window end strobe and the ones count of that window
    typedef struct packed {
        logic done;
        logic [CNT_W-1:0] ones;
    } window_t;

    // ones share bands, lowest to highest
    typedef enum logic [2:0] {
        band_low3,
        band_low2,
        band_low1,
        band_good,
        band_high1,
        band_high2,
        band_high3
    } band_e;

endpackage

// ==== hdl/run_detector.sv ====
`timescale 1ns/1ps

module run_detector #(
    parameter int C_INTER = 8,
    parameter int C_PERM = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  adc_in,
    input  logic                  full,
    output trng_pkg::run_flags_t  flags,
    output logic [C_PERM-1:0]     history
);

    // samples needed before the run checks are trusted
    localparam int ARM_SAMPLES = 32;
    localparam int ARM_W = $clog2(ARM_SAMPLES) + 1;

    logic [C_PERM-1:0] hist_q;
    logic [ARM_W-1:0]  arm_cnt;
    logic              armed;
    logic              inter_run;
    logic              rep_run;

    // newest sample enters at bit 0
    always_ff @(posedge clk) begin
        if (!rst) begin
            hist_q <= '0;
        end else if (!full) begin
            hist_q <= {hist_q[C_PERM-2:0], adc_in};
        end
    end

    // saturating count of accepted samples since reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            arm_cnt <= '0;
        end else if (!full && !armed) begin
            arm_cnt <= arm_cnt + 1'b1;
        end
    end

    assign armed = (arm_cnt == ARM_W'(ARM_SAMPLES));

    // a run is all ones or all zeros over the checked span
    assign inter_run = (hist_q[C_INTER-1:0] == '1) || (hist_q[C_INTER-1:0] == '0);
    assign rep_run = (hist_q[C_PERM-2:0] == '1) || (hist_q[C_PERM-2:0] == '0);

    always_comb begin
        flags.inter_fail = armed && inter_run;
        flags.rep_fail = armed && rep_run;
        // latest bit is the run value whenever either check fires
        flags.run_value = hist_q[0];
        flags.armed = armed;
    end

    assign history = hist_q;

endmodule

// ==== hdl/window_counter.sv ====
`timescale 1ns/1ps

module window_counter #(
    parameter int WINDOW_LEN = 1024
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  adc_in,
    input  logic                  full,
    input  trng_pkg::run_flags_t  flags,
    input  logic                  perm_fail,
    output trng_pkg::window_t     result
);

    localparam int SW = $clog2(WINDOW_LEN);
    localparam int CW = trng_pkg::CNT_W;

    logic [SW-1:0] sample_cnt;
    logic [CW-1:0] ones_cnt;
    logic [CW-1:0] ones_q;
    logic          done_q;
    logic          restart;
    logic          last_sample;

    // any fault throws the partial window away
    assign restart = flags.inter_fail || perm_fail;
    assign last_sample = (sample_cnt == SW'(WINDOW_LEN - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            sample_cnt <= '0;
            ones_cnt <= '0;
            done_q <= 1'b0;
        end else if (restart) begin
            sample_cnt <= '0;
            ones_cnt <= '0;
            done_q <= 1'b0;
        end else if (!full) begin
            // window length is a power of two, so the index wraps by itself
            sample_cnt <= sample_cnt + 1'b1;
            ones_cnt <= last_sample ? '0 : ones_cnt + CW'(adc_in);
            done_q <= last_sample;
        end else begin
            done_q <= 1'b0;
        end
    end

    // count of the window that just closed, including its last sample
    always_ff @(posedge clk) begin
        if (!restart && !full && last_sample) begin
            ones_q <= ones_cnt + CW'(adc_in);
        end
    end

    always_comb begin
        result.done = done_q;
        result.ones = ones_q;
    end

endmodule

// ==== hdl/calibration_controller.sv ====
`timescale 1ns/1ps

module calibration_controller #(
    parameter int WINDOW_LEN = 1024
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  full,
    input  logic                  debug_mode,
    input  logic [11:0]           spi_reg,
    input  trng_pkg::run_flags_t  flags,
    input  trng_pkg::window_t     result,
    output trng_pkg::trim_t       trim,
    output logic                  adaptive_fail,
    output logic                  locked
);

    localparam int CW = trng_pkg::CNT_W;
    localparam int TW = trng_pkg::TRIM_W;

    // upper bounds of each band as ones counts
    // a share that falls between two counts rounds up to the next whole count
    localparam logic [CW-1:0] TH_LOW3 = CW'(WINDOW_LEN / 8);
    localparam logic [CW-1:0] TH_LOW2 = CW'(WINDOW_LEN / 4);
    localparam logic [CW-1:0] TH_LOW1 = CW'((WINDOW_LEN * 45 + 99) / 100);
    localparam logic [CW-1:0] TH_GOOD = CW'((WINDOW_LEN * 55 + 99) / 100);
    localparam logic [CW-1:0] TH_HIGH1 = CW'(WINDOW_LEN * 3 / 4);
    localparam logic [CW-1:0] TH_HIGH2 = CW'(WINDOW_LEN * 7 / 8);

    trng_pkg::trim_t trim_q;
    trng_pkg::trim_t trim_next;
    trng_pkg::band_e band;
    logic            locked_q;
    logic            lock_next;
    logic            codes_maxed;

    // add a step and clamp at the top code
    function automatic logic [TW-1:0] sat_add(input logic [TW-1:0] code,
                                              input logic [1:0] step);
        logic [TW:0] sum;
        sum = {1'b0, code} + (TW+1)'(step);
        return sum[TW] ? '1 : sum[TW-1:0];
    endfunction

    always_comb begin
        if (result.ones < TH_LOW3) begin
            band = trng_pkg::band_low3;
        end else if (result.ones < TH_LOW2) begin
            band = trng_pkg::band_low2;
        end else if (result.ones < TH_LOW1) begin
            band = trng_pkg::band_low1;
        end else if (result.ones < TH_GOOD) begin
            band = trng_pkg::band_good;
        end else if (result.ones < TH_HIGH1) begin
            band = trng_pkg::band_high1;
        end else if (result.ones < TH_HIGH2) begin
            band = trng_pkg::band_high2;
        end else begin
            band = trng_pkg::band_high3;
        end
    end

    assign codes_maxed = (trim_q.n_trim == '1) && (trim_q.p_trim == '1);

    always_comb begin
        trim_next = trim_q;
        lock_next = locked_q;
        adaptive_fail = 1'b0;
        if (!full && flags.inter_fail) begin
            // push against the value of a stuck run
            if (codes_maxed) begin
                adaptive_fail = 1'b1;
            end else if (flags.run_value) begin
                trim_next.n_trim = sat_add(trim_q.n_trim, 2'd3);
            end else begin
                trim_next.p_trim = sat_add(trim_q.p_trim, 2'd3);
            end
        end else if (result.done && !flags.inter_fail) begin
            // a window closed by the last accepted sample still applies
            case (band)
                trng_pkg::band_low3:  trim_next.p_trim = sat_add(trim_q.p_trim, 2'd3);
                trng_pkg::band_low2:  trim_next.p_trim = sat_add(trim_q.p_trim, 2'd2);
                trng_pkg::band_low1:  trim_next.p_trim = sat_add(trim_q.p_trim, 2'd1);
                trng_pkg::band_good:  lock_next = 1'b1;
                trng_pkg::band_high1: trim_next.n_trim = sat_add(trim_q.n_trim, 2'd1);
                trng_pkg::band_high2: trim_next.n_trim = sat_add(trim_q.n_trim, 2'd2);
                trng_pkg::band_high3: trim_next.n_trim = sat_add(trim_q.n_trim, 2'd3);
                default:              lock_next = locked_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            trim_q <= '0;
            locked_q <= 1'b0;
        end else if (debug_mode) begin
            // register image wins over every loop update
            trim_q <= trng_pkg::trim_t'(spi_reg);
        end else begin
            trim_q <= trim_next;
            locked_q <= lock_next;
        end
    end

    assign trim = trim_q;
    assign locked = locked_q;

endmodule

// ==== hdl/entropy_packer.sv ====
`timescale 1ns/1ps

module entropy_packer #(
    parameter int WORD_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              full,
    input  logic              locked,
    input  logic              bit_in,
    output logic [WORD_W-1:0] word,
    output logic              valid
);

    localparam int BW = $clog2(WORD_W);

    logic [WORD_W-1:0] shift_q;
    logic [WORD_W-1:0] shift_next;
    logic [BW-1:0]     bit_cnt;
    logic              take;
    logic              word_done;

    assign take = locked && !full;
    assign word_done = take && (bit_cnt == BW'(WORD_W - 1));

    // shifting left leaves the first bit at the msb
    assign shift_next = {shift_q[WORD_W-2:0], bit_in};

    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_cnt <= '0;
            valid <= 1'b0;
        end else begin
            valid <= word_done;
            if (word_done) begin
                bit_cnt <= '0;
            end else if (take) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            shift_q <= shift_next;
        end
        if (word_done) begin
            word <= shift_next;
        end
    end

endmodule

// ==== hdl/trng_health_top.sv ====
`timescale 1ns/1ps

module trng_health_top #(
    parameter int WINDOW_LEN = trng_pkg::DEF_WINDOW_LEN,
    parameter int C_INTER = trng_pkg::DEF_C_INTER,
    parameter int C_PERM = trng_pkg::DEF_C_PERM,
    parameter int WORD_W = trng_pkg::DEF_WORD_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              adc_in,
    input  logic              full,
    input  logic              debug_mode,
    input  logic [11:0]       spi_reg,
    output trng_pkg::trim_t   trim,
    output logic              perm_fail,
    output logic              locked,
    output logic [WORD_W-1:0] word,
    output logic              valid
);

    trng_pkg::run_flags_t flags;
    trng_pkg::window_t    result;
    logic [C_PERM-1:0]    history;
    logic                 adaptive_fail;
    logic                 perm_fail_q;

    run_detector #(
        .C_INTER (C_INTER),
        .C_PERM  (C_PERM)
    ) i_run_detector (
        .clk     (clk),
        .rst     (rst),
        .adc_in  (adc_in),
        .full    (full),
        .flags   (flags),
        .history (history)
    );

    window_counter #(
        .WINDOW_LEN (WINDOW_LEN)
    ) i_window_counter (
        .clk       (clk),
        .rst       (rst),
        .adc_in    (adc_in),
        .full      (full),
        .flags     (flags),
        .perm_fail (perm_fail_q),
        .result    (result)
    );

    calibration_controller #(
        .WINDOW_LEN (WINDOW_LEN)
    ) i_calibration_controller (
        .clk           (clk),
        .rst           (rst),
        .full          (full),
        .debug_mode    (debug_mode),
        .spi_reg       (spi_reg),
        .flags         (flags),
        .result        (result),
        .trim          (trim),
        .adaptive_fail (adaptive_fail),
        .locked        (locked)
    );

    // packer follows the newest bit of the history register
    entropy_packer #(
        .WORD_W (WORD_W)
    ) i_entropy_packer (
        .clk    (clk),
        .rst    (rst),
        .full   (full),
        .locked (locked),
        .bit_in (history[0]),
        .word   (word),
        .valid  (valid)
    );

    // repetition fault with no trim range left, kept until reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            perm_fail_q <= 1'b0;
        end else if (flags.rep_fail && adaptive_fail) begin
            perm_fail_q <= 1'b1;
        end
    end

    assign perm_fail = perm_fail_q;

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// ==== verification/tb_health_model.svh ====
`ifndef TB_HEALTH_MODEL_SVH
`define TB_HEALTH_MODEL_SVH

// model state after the most recent rising edge
logic [C_PERM-1:0] m_hist;
int                m_arm;
int                m_samp;
int                m_ones;
int                m_win_ones;
logic              m_done;
trng_pkg::trim_t   m_trim;
logic              m_locked;
logic              m_perm;
logic [WORD_W-1:0] m_shift;
int                m_bits;
logic [WORD_W-1:0] m_word;
logic              m_valid;
int                errors;

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

// share bands taken from the exact fractions of the window
function automatic trng_pkg::band_e band_of(input int ones);
    if (ones * 8 < WINDOW_LEN) return trng_pkg::band_low3;
    if (ones * 4 < WINDOW_LEN) return trng_pkg::band_low2;
    if (ones * 100 < WINDOW_LEN * 45) return trng_pkg::band_low1;
    if (ones * 100 < WINDOW_LEN * 55) return trng_pkg::band_good;
    if (ones * 4 < WINDOW_LEN * 3) return trng_pkg::band_high1;
    if (ones * 8 < WINDOW_LEN * 7) return trng_pkg::band_high2;
    return trng_pkg::band_high3;
endfunction

function automatic logic [5:0] sat_step(input logic [5:0] code, input int step);
    int sum;
    sum = int'(code) + step;
    return (sum > 63) ? 6'd63 : 6'(sum);
endfunction

task automatic model_reset();
    m_hist = '0;
    m_arm = 0;
    m_samp = 0;
    m_ones = 0;
    m_win_ones = 0;
    m_done = 1'b0;
    m_trim = '0;
    m_locked = 1'b0;
    m_perm = 1'b0;
    m_shift = '0;
    m_bits = 0;
    m_word = '0;
    m_valid = 1'b0;
endtask

// advance the model by one rising edge with the given inputs
task automatic model_step(input logic a, input logic f, input logic dbg,
                          input logic [11:0] spi);
    logic            armed;
    logic            inter;
    logic            rep;
    logic            restart;
    logic            afail;
    logic            lock_n;
    logic            last;
    trng_pkg::trim_t t_next;
    trng_pkg::band_e band;
    armed = (m_arm >= 32);
    inter = armed && ((&m_hist[C_INTER-1:0]) || !(|m_hist[C_INTER-1:0]));
    rep = armed && ((&m_hist[C_PERM-2:0]) || !(|m_hist[C_PERM-2:0]));
    restart = inter || m_perm;
    last = (m_samp == WINDOW_LEN - 1);
    band = band_of(m_win_ones);
    afail = 1'b0;
    t_next = m_trim;
    lock_n = m_locked;

    // packer takes the newest history bit while locked
    m_valid = 1'b0;
    if (m_locked && !f) begin
        m_shift = {m_shift[WORD_W-2:0], m_hist[0]};
        if (m_bits == WORD_W - 1) begin
            m_word = m_shift;
            m_valid = 1'b1;
            m_bits = 0;
        end else begin
            m_bits++;
        end
    end

    if (!f && inter) begin
        if (&m_trim) begin
            afail = 1'b1;
        end else if (m_hist[0]) begin
            t_next.n_trim = sat_step(m_trim.n_trim, 3);
        end else begin
            t_next.p_trim = sat_step(m_trim.p_trim, 3);
        end
    end else if (m_done && !inter) begin
        case (band)
            trng_pkg::band_low3:  t_next.p_trim = sat_step(m_trim.p_trim, 3);
            trng_pkg::band_low2:  t_next.p_trim = sat_step(m_trim.p_trim, 2);
            trng_pkg::band_low1:  t_next.p_trim = sat_step(m_trim.p_trim, 1);
            trng_pkg::band_good:  lock_n = 1'b1;
            trng_pkg::band_high1: t_next.n_trim = sat_step(m_trim.n_trim, 1);
            trng_pkg::band_high2: t_next.n_trim = sat_step(m_trim.n_trim, 2);
            default:              t_next.n_trim = sat_step(m_trim.n_trim, 3);
        endcase
    end
    if (dbg) begin
        m_trim = trng_pkg::trim_t'(spi);
    end else begin
        m_trim = t_next;
        m_locked = lock_n;
    end
    if (rep && afail) m_perm = 1'b1;

    if (restart) begin
        m_samp = 0;
        m_ones = 0;
        m_done = 1'b0;
    end else if (!f) begin
        m_done = last;
        if (last) begin
            m_win_ones = m_ones + int'(a);
            m_ones = 0;
        end else begin
            m_ones = m_ones + int'(a);
        end
        m_samp = (m_samp + 1) % WINDOW_LEN;
    end else begin
        m_done = 1'b0;
    end

    if (!f) begin
        m_hist = {m_hist[C_PERM-2:0], a};
        if (m_arm < 32) m_arm++;
    end
endtask

task automatic check_trim(input string name, input trng_pkg::trim_t got,
                          input trng_pkg::trim_t exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                          input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

`endif

// ==== verification/tb_trng_health.sv ====
`timescale 1ns/1ps

module tb_trng_health;

    localparam int WINDOW_LEN = 64;
    localparam int C_INTER = 6;
    localparam int C_PERM = trng_pkg::DEF_C_PERM;
    localparam int WORD_W = trng_pkg::DEF_WORD_W;

    logic              clk;
    logic              rst;
    logic              adc_in;
    logic              full;
    logic              debug_mode;
    logic [11:0]       spi_reg;
    trng_pkg::trim_t   trim;
    logic              perm_fail;
    logic              locked;
    logic [WORD_W-1:0] word;
    logic              valid;

    logic [31:0] lfsr;
    logic        last_bit;
    int          run_len;
    int          valid_count;
    int          timeouts;

    `include "tb_health_model.svh"

    tb_clock_gen i_clock_gen (.clk(clk));

    trng_health_top #(
        .WINDOW_LEN (WINDOW_LEN),
        .C_INTER    (C_INTER),
        .C_PERM     (C_PERM),
        .WORD_W     (WORD_W)
    ) i_trng_health_top (
        .clk        (clk),
        .rst        (rst),
        .adc_in     (adc_in),
        .full       (full),
        .debug_mode (debug_mode),
        .spi_reg    (spi_reg),
        .trim       (trim),
        .perm_fail  (perm_fail),
        .locked     (locked),
        .word       (word),
        .valid      (valid)
    );

    task automatic draw_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    // drive on the falling edge, compare at the next falling edge
    task automatic step_cycle(input logic a, input logic f);
        adc_in = a;
        full = f;
        model_step(a, f, debug_mode, spi_reg);
        if (!f) begin
            run_len = (a == last_bit) ? run_len + 1 : 1;
            last_bit = a;
        end
        @(negedge clk);
        check_trim("trim", trim, m_trim);
        check_flag("locked", locked, m_locked);
        check_flag("perm_fail", perm_fail, m_perm);
        check_flag("valid", valid, m_valid);
        if (m_valid) check_word("word", word, m_word);
        if (valid) valid_count++;
    endtask

    // bias 0 to 4 gives a ones share of about 1/8, 1/4, 1/2, 3/4, 7/8
    task automatic drive_random(input int bias, input logic f);
        logic b;
        logic r;
        draw_bit(b);
        if (bias != 2) begin
            draw_bit(r);
            b = (bias < 2) ? (b & r) : (b | r);
        end
        if (bias == 0 || bias == 4) begin
            draw_bit(r);
            b = (bias == 0) ? (b & r) : (b | r);
        end
        // keep runs short of the interrupt length
        if (run_len >= C_INTER - 1 && b == last_bit) b = ~b;
        step_cycle(b, f);
    endtask

    task automatic drive_run(input logic value, input int len);
        repeat (len) step_cycle(value, 1'b0);
    endtask

    task automatic wait_valids(input int count);
        int target;
        int n;
        target = valid_count + count;
        n = 0;
        while (valid_count < target && n < count * WORD_W * 4) begin
            drive_random(2, 1'b0);
            n++;
        end
        if (valid_count < target) begin
            timeouts++;
            $display("timeout: %0d output words did not arrive", count);
        end
    endtask

    initial begin
        trng_pkg::trim_t trim_before;
        logic [5:0]      code_before;
        logic [11:0]     spi_val;
        logic            b;
        int              valid_before;
        int              n;
        rst = 1'b0;
        adc_in = 1'b0;
        full = 1'b0;
        debug_mode = 1'b0;
        spi_reg = '0;
        lfsr = 32'h9aeb;
        last_bit = 1'b0;
        run_len = 0;
        valid_count = 0;
        timeouts = 0;
        errors = 0;
        model_reset();
        repeat (5) @(negedge clk);
        rst = 1'b1;
        check_trim("trim after reset", trim, '0);
        check_flag("valid after reset", valid, 1'b0);
        check_flag("locked after reset", locked, 1'b0);
        check_flag("perm_fail after reset", perm_fail, 1'b0);

        // biased windows push the opposite code up
        repeat (16 * WINDOW_LEN) drive_random(4, 1'b0);
        repeat (8 * WINDOW_LEN) drive_random(3, 1'b0);
        check_flag("n_trim raised by ones-heavy stream", trim.n_trim != '0, 1'b1);
        code_before = trim.p_trim;
        repeat (16 * WINDOW_LEN) drive_random(0, 1'b0);
        repeat (8 * WINDOW_LEN) drive_random(1, 1'b0);
        check_flag("p_trim raised by zeros-heavy stream", trim.p_trim > code_before, 1'b1);

        n = 0;
        while (!locked && n < 40 * WINDOW_LEN) begin
            drive_random(2, 1'b0);
            n++;
        end
        if (!locked) begin
            timeouts++;
            $display("timeout: locked did not rise on a balanced stream");
        end
        wait_valids(6);

        // a window closed just before full still lands on the first held cycle
        drive_random(2, 1'b1);
        trim_before = trim;
        valid_before = valid_count;
        repeat (3 * WINDOW_LEN) drive_random(2, 1'b1);
        check_trim("trim held under full", trim, trim_before);
        check_flag("valid seen under full", valid_count != valid_before, 1'b0);
        wait_valids(4);

        for (int i = 0; i < 12; i++) begin
            draw_bit(b);
            spi_val = {spi_val[10:0], b};
        end
        debug_mode = 1'b1;
        spi_reg = spi_val;
        drive_random(2, 1'b0);
        check_trim("trim loaded from spi_reg", trim, trng_pkg::trim_t'(spi_val));
        drive_run(1'b1, 10);
        drive_run(1'b0, 10);
        repeat (2 * WINDOW_LEN) drive_random(3, 1'b0);
        check_trim("trim held in debug_mode", trim, trng_pkg::trim_t'(spi_val));
        debug_mode = 1'b0;

        code_before = trim.n_trim;
        drive_run(1'b1, 8);
        check_flag("n_trim stepped by run of ones",
                   (trim.n_trim > code_before) || (code_before == 6'd63), 1'b1);
        n = 0;
        while (!(&trim) && n < 40) begin
            drive_run(1'b1, 8);
            drive_run(1'b0, 8);
            n++;
        end
        if (!(&trim)) begin
            timeouts++;
            $display("timeout: trim codes did not saturate under forced runs");
        end
        n = 0;
        while (!perm_fail && n < 4 * C_PERM) begin
            step_cycle(1'b1, 1'b0);
            n++;
        end
        if (!perm_fail) begin
            timeouts++;
            $display("timeout: perm_fail did not rise on a long run at saturated trim");
        end
        repeat (2 * WINDOW_LEN) drive_random(2, 1'b0);
        check_flag("perm_fail sticky", perm_fail, 1'b1);

        $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verification
hdl/trng_pkg.sv
hdl/run_detector.sv
hdl/window_counter.sv
hdl/calibration_controller.sv
hdl/entropy_packer.sv
hdl/trng_health_top.sv
verification/tb_clock_gen.sv
verification/tb_trng_health.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_trng_health
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
